// File: rtl/ctxRegMacros_macros.svh
// Register context parameters
`ifndef CTX_REG_MACROS_SVH
`define CTX_REG_MACROS_SVH

`define CTX_DATA_WIDTH      32  // register word
`define CTX_NUM_REGS        32  // registers per bank
`define CTX_REG_ADDR_WIDTH  5
`define CTX_NUM_LEVELS      8   // banks, level 0 is thread mode
`define CTX_LEVEL_WIDTH     3
`define CTX_NUM_IRQS        (`CTX_NUM_LEVELS - 1)

`define CTX_REQ_DEPTH       4   // also the sender's initial credits
`define CTX_REQ_PTR_WIDTH   2
`define CTX_REQ_CNT_WIDTH   3   // holds 0 to depth

`define CTX_RESP_CREDITS    2   // response credits held after reset
`define CTX_RESP_CNT_WIDTH  2

`endif

// File: rtl/ctxRegPkg.sv
// Register context types
`include "ctxRegMacros_macros.svh"

package ctxRegPkg;

  typedef logic [`CTX_DATA_WIDTH-1:0] dataT;
  typedef logic [`CTX_REG_ADDR_WIDTH-1:0] regAddrT;
  typedef logic [`CTX_LEVEL_WIDTH-1:0] levelT;

  // access kinds on the request channel
  typedef enum logic [1:0] {
    RegRead      = 2'd0,  // two reads, no write
    RegWrite     = 2'd1,  // write only
    RegReadWrite = 2'd2   // write plus two reads, same cycle
  } regOpT;

  typedef struct packed {
    regOpT   op;
    regAddrT writeAddr;
    dataT    writeData;
    regAddrT readAddr1;
    regAddrT readAddr2;
  } regReqT;

  // read results as sampled at issue
  typedef struct packed {
    dataT  readData1;
    dataT  readData2;
    dataT  readRa;     // ra of the level at issue
    levelT level;
  } regRespT;

  // interrupt entry sequencing
  typedef enum logic {
    LvlIdle = 1'b0,
    LvlMark = 1'b1  // ra marker write cycle
  } levelStateT;

endpackage

// File: rtl/rfStack.sv
// Banked register file
`timescale 1ns/100ps
`include "ctxRegMacros_macros.svh"

module rfStack (
  input  logic               clk,
  input  logic               reset,
  input  logic               writeEn,
  input  logic               raMarkEn,
  input  ctxRegPkg::levelT   level,
  input  ctxRegPkg::regAddrT writeAddr,
  input  ctxRegPkg::dataT    writeData,
  input  ctxRegPkg::regAddrT readAddr1,
  input  ctxRegPkg::regAddrT readAddr2,
  output ctxRegPkg::dataT    readData1,
  output ctxRegPkg::dataT    readData2,
  output ctxRegPkg::dataT    readRa
);

  localparam ctxRegPkg::regAddrT zeroAddr = 5'd0;  // x0
  localparam ctxRegPkg::regAddrT raAddr   = 5'd1;  // x1
  localparam ctxRegPkg::regAddrT spAddr   = 5'd2;  // x2

  ctxRegPkg::dataT    banks [`CTX_NUM_LEVELS][`CTX_NUM_REGS];
  ctxRegPkg::levelT   writeBank;
  ctxRegPkg::regAddrT rdAddr [2];
  ctxRegPkg::dataT    rdData [2];

  // sp is shared, it only exists in bank 0
  always_comb writeBank = (writeAddr == spAddr) ? '0 : level;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int l = 0; l < `CTX_NUM_LEVELS; l++) begin
        for (int r = 0; r < `CTX_NUM_REGS; r++) begin
          banks[l][r] <= '0;
        end
      end
    end else begin
      if (writeEn && (writeAddr != zeroAddr)) begin
        banks[writeBank][writeAddr] <= writeData;
      end
      if (raMarkEn) begin
        banks[level][raAddr] <= '1;  // last assignment, marker wins
      end
    end
  end

  // both read ports share the same selection
  always_comb begin
    rdAddr[0] = readAddr1;
    rdAddr[1] = readAddr2;
    for (int p = 0; p < 2; p++) begin
      if (rdAddr[p] == zeroAddr) begin
        rdData[p] = '0;  // hardwired zero
      end else if (raMarkEn && (rdAddr[p] == raAddr)) begin
        rdData[p] = '1;  // marker being written
      end else if (writeEn && (rdAddr[p] == writeAddr)) begin
        rdData[p] = writeData;  // write-through
      end else if (rdAddr[p] == spAddr) begin
        rdData[p] = banks[0][spAddr];
      end else begin
        rdData[p] = banks[level][rdAddr[p]];
      end
    end
  end

  assign readData1 = rdData[0];
  assign readData2 = rdData[1];
  assign readRa    = banks[level][raAddr];  // current ra, no bypass

endmodule

// File: rtl/irqLevelCtrl.sv
// Interrupt level controller
`timescale 1ns/100ps
`include "ctxRegMacros_macros.svh"

module irqLevelCtrl (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`CTX_NUM_IRQS-1:0] irqPending,
  input  logic                     irqReturn,
  output logic [`CTX_NUM_IRQS-1:0] irqAck,
  output ctxRegPkg::levelT         curLevel,
  output logic                     raMarkEn
);

  ctxRegPkg::levelStateT    state;
  ctxRegPkg::levelT         stackMem [`CTX_NUM_LEVELS];
  ctxRegPkg::levelT         stackPtr;   // number of saved levels
  ctxRegPkg::levelT         popPtr;
  logic                     hitValid;
  ctxRegPkg::levelT         hitLevel;
  logic [`CTX_NUM_IRQS-1:0] hitOneHot;
  logic                     doReturn;
  logic                     takeIrq;

  // fixed priority, irq i sits at level i+1 so the highest index wins
  always_comb begin
    hitValid  = 1'b0;
    hitLevel  = '0;
    hitOneHot = '0;
    for (int i = 0; i < `CTX_NUM_IRQS; i++) begin
      if (irqPending[i]) begin
        hitValid     = 1'b1;
        hitLevel     = ctxRegPkg::levelT'(i + 1);
        hitOneHot    = '0;
        hitOneHot[i] = 1'b1;
      end
    end
  end

  assign popPtr = stackPtr - 3'd1;

  // a return takes the cycle, a pending entry is retried afterwards
  assign doReturn = (state == ctxRegPkg::LvlIdle) && irqReturn && (stackPtr != '0);
  assign takeIrq  = (state == ctxRegPkg::LvlIdle) && !doReturn && hitValid &&
                    (hitLevel > curLevel);

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ctxRegPkg::LvlIdle;
      curLevel <= '0;
      stackPtr <= '0;
      irqAck   <= '0;
    end else begin
      irqAck <= '0;  // single cycle pulse
      case (state)
        ctxRegPkg::LvlIdle: begin
          if (doReturn) begin
            curLevel <= stackMem[popPtr];  // back to the interrupted level
            stackPtr <= popPtr;
          end else if (takeIrq) begin
            curLevel <= hitLevel;
            stackPtr <= stackPtr + 3'd1;
            irqAck   <= hitOneHot;
            state    <= ctxRegPkg::LvlMark;
          end
        end
        ctxRegPkg::LvlMark: begin
          state <= ctxRegPkg::LvlIdle;  // marker written this cycle
        end
        default: begin
          state <= ctxRegPkg::LvlIdle;
        end
      endcase
    end
  end

  // saved levels, only the pointer is cleared
  always_ff @(posedge clk) begin
    if (takeIrq) begin
      stackMem[stackPtr] <= curLevel;
    end
  end

  // curLevel already holds the new level during the mark cycle
  assign raMarkEn = (state == ctxRegPkg::LvlMark);

endmodule

// File: rtl/regReqQueue.sv
// Credited register request queue
`timescale 1ns/100ps
`include "ctxRegMacros_macros.svh"

module regReqQueue (
  input  logic                clk,
  input  logic                reset,
  input  logic                reqValid,
  input  ctxRegPkg::regReqT   req,
  output logic                reqCredit,
  input  logic                respCredit,
  output logic                respValid,
  output ctxRegPkg::regRespT  resp,
  output logic                writeEn,
  output ctxRegPkg::regAddrT  writeAddr,
  output ctxRegPkg::dataT     writeData,
  output ctxRegPkg::regAddrT  readAddr1,
  output ctxRegPkg::regAddrT  readAddr2,
  input  ctxRegPkg::dataT     readData1,
  input  ctxRegPkg::dataT     readData2,
  input  ctxRegPkg::dataT     readRa,
  input  ctxRegPkg::levelT    level
);

  ctxRegPkg::regReqT              fifoMem [`CTX_REQ_DEPTH];
  logic [`CTX_REQ_PTR_WIDTH-1:0]  wrPtr;
  logic [`CTX_REQ_PTR_WIDTH-1:0]  rdPtr;
  logic [`CTX_REQ_CNT_WIDTH-1:0]  count;
  logic [`CTX_RESP_CNT_WIDTH-1:0] respCredits;
  ctxRegPkg::regReqT              head;
  logic                           issue;
  logic                           readsRegs;

  assign head  = fifoMem[rdPtr];
  assign issue = (count != '0) && (respCredits != '0);  // one access per cycle

  // op decode toward the bank
  assign readsRegs = (head.op != ctxRegPkg::RegWrite);
  assign writeEn   = issue && (head.op != ctxRegPkg::RegRead);
  assign writeAddr = head.writeAddr;
  assign writeData = head.writeData;
  assign readAddr1 = readsRegs ? head.readAddr1 : '0;  // x0 reads as zero
  assign readAddr2 = readsRegs ? head.readAddr2 : '0;

  // the sender holds credits, so every valid request has a free slot
  always_ff @(posedge clk) begin
    if (reqValid) begin
      fifoMem[wrPtr] <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr       <= '0;
      rdPtr       <= '0;
      count       <= '0;
      respCredits <= `CTX_RESP_CNT_WIDTH'(`CTX_RESP_CREDITS);
    end else begin
      if (reqValid) wrPtr <= wrPtr + 1'b1;  // depth is a power of two
      if (issue) rdPtr <= rdPtr + 1'b1;
      case ({reqValid, issue})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      case ({respCredit, issue})
        2'b10:   respCredits <= respCredits + 1'b1;
        2'b01:   respCredits <= respCredits - 1'b1;
        default: respCredits <= respCredits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      reqCredit <= 1'b0;
      respValid <= 1'b0;
    end else begin
      reqCredit <= issue;  // slot freed
      respValid <= issue;
    end
  end

  // bank outputs sampled at the issue edge
  always_ff @(posedge clk) begin
    if (issue) begin
      resp.readData1 <= readData1;
      resp.readData2 <= readData2;
      resp.readRa    <= readRa;
      resp.level     <= level;
    end
  end

endmodule

// File: rtl/ctxRegTop.sv
// Register context unit top
`timescale 1ns/100ps
`include "ctxRegMacros_macros.svh"

module ctxRegTop (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     reqValid,
  input  ctxRegPkg::regReqT        req,
  output logic                     reqCredit,
  input  logic                     respCredit,
  output logic                     respValid,
  output ctxRegPkg::regRespT       resp,
  input  logic [`CTX_NUM_IRQS-1:0] irqPending,
  input  logic                     irqReturn,
  output logic [`CTX_NUM_IRQS-1:0] irqAck,
  output ctxRegPkg::levelT         curLevel
);

  logic               writeEn;
  logic               raMarkEn;
  ctxRegPkg::regAddrT writeAddr;
  ctxRegPkg::dataT    writeData;
  ctxRegPkg::regAddrT readAddr1;
  ctxRegPkg::regAddrT readAddr2;
  ctxRegPkg::dataT    readData1;
  ctxRegPkg::dataT    readData2;
  ctxRegPkg::dataT    readRa;

  regReqQueue queue0 (
    .clk        (clk),
    .reset      (reset),
    .reqValid   (reqValid),
    .req        (req),
    .reqCredit  (reqCredit),
    .respCredit (respCredit),
    .respValid  (respValid),
    .resp       (resp),
    .writeEn    (writeEn),
    .writeAddr  (writeAddr),
    .writeData  (writeData),
    .readAddr1  (readAddr1),
    .readAddr2  (readAddr2),
    .readData1  (readData1),
    .readData2  (readData2),
    .readRa     (readRa),
    .level      (curLevel)
  );

  irqLevelCtrl lvl0 (
    .clk        (clk),
    .reset      (reset),
    .irqPending (irqPending),
    .irqReturn  (irqReturn),
    .irqAck     (irqAck),
    .curLevel   (curLevel),
    .raMarkEn   (raMarkEn)
  );

  rfStack rf0 (
    .clk        (clk),
    .reset      (reset),
    .writeEn    (writeEn),
    .raMarkEn   (raMarkEn),
    .level      (curLevel),  // bank follows the active level
    .writeAddr  (writeAddr),
    .writeData  (writeData),
    .readAddr1  (readAddr1),
    .readAddr2  (readAddr2),
    .readData1  (readData1),
    .readData2  (readData2),
    .readRa     (readRa)
  );

endmodule

// File: verif/ctxRegTb.sv
// Register context unit testbench
`timescale 1ns/100ps
`include "ctxRegMacros_macros.svh"

module ctxRegTb;

  localparam int Timeout = 50;  // cycles per wait

  logic                     clk;
  logic                     reset;
  logic                     reqValid;
  ctxRegPkg::regReqT        req;
  logic                     reqCredit;
  logic                     respCredit;
  logic                     respValid;
  ctxRegPkg::regRespT       resp;
  logic [`CTX_NUM_IRQS-1:0] irqPending;
  logic                     irqReturn;
  logic [`CTX_NUM_IRQS-1:0] irqAck;
  ctxRegPkg::levelT         curLevel;

  ctxRegPkg::dataT    modelBank [`CTX_NUM_LEVELS][`CTX_NUM_REGS];
  ctxRegPkg::levelT   modelLevel;
  ctxRegPkg::levelT   modelStack [$];  // interrupted levels
  ctxRegPkg::regRespT expQ [$];        // responses in issue order

  int     errors;
  int     checks;
  int     sentCount;
  int     creditsBack;  // reqCredit pulses seen
  int     respCount;
  int     owed;         // response credits not yet returned
  bit     holdCredits;
  integer seed;
  string  curTest;

  ctxRegTop dut0 (
    .clk        (clk),
    .reset      (reset),
    .reqValid   (reqValid),
    .req        (req),
    .reqCredit  (reqCredit),
    .respCredit (respCredit),
    .respValid  (respValid),
    .resp       (resp),
    .irqPending (irqPending),
    .irqReturn  (irqReturn),
    .irqAck     (irqAck),
    .curLevel   (curLevel)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", curTest, what, expected, actual);
    end
  endtask

  task automatic finishRun();
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  task automatic abortRun(input string msg);
    errors++;
    $display("Timeout in %s: %s", curTest, msg);
    finishRun();
  endtask

  task automatic compareResp(input ctxRegPkg::regRespT expResp);
    checkValue("readData1", expResp.readData1, resp.readData1);
    checkValue("readData2", expResp.readData2, resp.readData2);
    checkValue("readRa", expResp.readRa, resp.readRa);
    checkValue("level", 32'(expResp.level), 32'(resp.level));
  endtask

  // one clock edge: observe outputs, then drive defaults
  task automatic cycle();
    @(posedge clk);
    if (reqCredit === 1'b1) creditsBack++;
    if (respValid === 1'b1) begin
      respCount++;
      owed++;
      if (expQ.size() == 0) begin
        errors++;
        $display("Unexpected response in %s", curTest);
      end else begin
        compareResp(expQ.pop_front());
      end
    end
    reqValid  <= 1'b0;
    irqReturn <= 1'b0;
    if (!holdCredits && owed > 0) begin
      respCredit <= 1'b1;  // one credit back per cycle
      owed--;
    end else begin
      respCredit <= 1'b0;
    end
  endtask

  task automatic clearModel();
    for (int l = 0; l < `CTX_NUM_LEVELS; l++) begin
      for (int r = 0; r < `CTX_NUM_REGS; r++) begin
        modelBank[l][r] = '0;
      end
    end
    modelLevel = '0;
    modelStack.delete();
  endtask

  function automatic ctxRegPkg::dataT modelRead(input ctxRegPkg::regAddrT addr,
                                                input ctxRegPkg::regReqT r, input bit wr);
    if (addr == 5'd0) return '0;
    if (wr && addr == r.writeAddr) return r.writeData;  // same access bypass
    if (addr == 5'd2) return modelBank[0][2];             // shared sp
    return modelBank[modelLevel][addr];
  endfunction

  task automatic modelAccess(input ctxRegPkg::regReqT r, output ctxRegPkg::regRespT rs);
    bit wr;
    bit rd;
    wr = (r.op != ctxRegPkg::RegRead);
    rd = (r.op != ctxRegPkg::RegWrite);
    rs.readData1 = rd ? modelRead(r.readAddr1, r, wr) : '0;
    rs.readData2 = rd ? modelRead(r.readAddr2, r, wr) : '0;
    rs.readRa    = modelBank[modelLevel][1];  // value before this write
    rs.level     = modelLevel;
    if (wr && r.writeAddr == 5'd2) begin
      modelBank[0][2] = r.writeData;
    end else if (wr && r.writeAddr != 5'd0) begin
      modelBank[modelLevel][r.writeAddr] = r.writeData;
    end
  endtask

  function automatic ctxRegPkg::regReqT makeReq(input ctxRegPkg::regOpT op, input int wa,
                                                input ctxRegPkg::dataT wd, input int ra1,
                                                input int ra2);
    ctxRegPkg::regReqT r;
    r.op        = op;
    r.writeAddr = ctxRegPkg::regAddrT'(wa);
    r.writeData = wd;
    r.readAddr1 = ctxRegPkg::regAddrT'(ra1);
    r.readAddr2 = ctxRegPkg::regAddrT'(ra2);
    return r;
  endfunction

  task automatic sendReq(input ctxRegPkg::regReqT r);
    ctxRegPkg::regRespT expResp;
    int waited;
    waited = 0;
    cycle();
    while (sentCount - creditsBack >= `CTX_REQ_DEPTH && waited < Timeout) begin
      cycle();
      waited++;
    end
    if (sentCount - creditsBack >= `CTX_REQ_DEPTH) begin
      abortRun("no request credit came back");
    end else begin
      reqValid <= 1'b1;
      req      <= r;
      sentCount++;
      modelAccess(r, expResp);
      expQ.push_back(expResp);
    end
  endtask

  task automatic waitResponses();
    int waited;
    waited = 0;
    while (expQ.size() > 0 && waited < Timeout) begin
      cycle();
      waited++;
    end
    if (expQ.size() > 0) abortRun("expected responses did not arrive");
  endtask

  task automatic enterIrq(input int i);
    logic [`CTX_NUM_IRQS-1:0] expAck;
    int waited;
    expAck    = '0;
    expAck[i] = 1'b1;
    waited    = 0;
    cycle();
    irqPending[i] <= 1'b1;
    cycle();
    while (irqAck === '0 && waited < Timeout) begin
      cycle();
      waited++;
    end
    if (irqAck === '0) begin
      abortRun("interrupt was never acknowledged");
    end else begin
      checkValue("irqAck", 32'(expAck), 32'(irqAck));
      irqPending[i] <= 1'b0;  // source drops after ack
      modelStack.push_back(modelLevel);
      modelLevel = ctxRegPkg::levelT'(i + 1);
      modelBank[modelLevel][1] = '1;  // return marker
      checkValue("curLevel", 32'(modelLevel), 32'(curLevel));
    end
  endtask

  task automatic returnFromIrq();
    cycle();
    irqReturn <= 1'b1;
    cycle();
    cycle();
    if (modelStack.size() > 0) modelLevel = modelStack.pop_back();
    checkValue("curLevel", 32'(modelLevel), 32'(curLevel));
  endtask

  task automatic checkNoAck(input int n);
    repeat (n) begin
      cycle();
      checkValue("irqAck", 32'd0, 32'(irqAck));
    end
  endtask

  task automatic basicAccess();
    curTest = "basicAccess";
    for (int i = 0; i < 4; i++) begin
      sendReq(makeReq(ctxRegPkg::RegWrite, 5 + i, $random(seed), 0, 0));
    end
    sendReq(makeReq(ctxRegPkg::RegRead, 0, '0, 5, 6));
    sendReq(makeReq(ctxRegPkg::RegRead, 0, '0, 7, 8));
    sendReq(makeReq(ctxRegPkg::RegWrite, 0, $random(seed), 0, 0));  // x0 stays zero
    sendReq(makeReq(ctxRegPkg::RegRead, 0, '0, 0, 5));
    sendReq(makeReq(ctxRegPkg::RegReadWrite, 9, $random(seed), 9, 5));
    sendReq(makeReq(ctxRegPkg::RegRead, 0, '0, 9, 0));
    waitResponses();
  endtask

  task automatic irqBanking();
    curTest = "irqBanking";
    enterIrq(2);
    checkValue("curLevel", 32'd3, 32'(curLevel));
    sendReq(makeReq(ctxRegPkg::RegRead, 0, '0, 1, 0));  // ra marker
    sendReq(makeReq(ctxRegPkg::RegWrite, 5, $random(seed), 0, 0));
    sendReq(makeReq(ctxRegPkg::RegWrite, 6, $random(seed), 0, 0));
    sendReq(makeReq(ctxRegPkg::RegWrite, 2, $random(seed), 0, 0));
    sendReq(makeReq(ctxRegPkg::RegRead, 0, '0, 5, 2));
    waitResponses();
    returnFromIrq();
    sendReq(makeReq(ctxRegPkg::RegRead, 0, '0, 5, 6));  // level 0 untouched
    sendReq(makeReq(ctxRegPkg::RegRead, 0, '0, 2, 1));
    waitResponses();
  endtask

  task automatic nesting();
    curTest = "nesting";
    enterIrq(2);
    cycle();
    irqPending[1] <= 1'b1;  // level 2, below current
    checkNoAck(8);
    checkValue("curLevel", 32'd3, 32'(curLevel));
    enterIrq(5);
    checkValue("curLevel", 32'd6, 32'(curLevel));
    cycle();
    irqPending[1] <= 1'b0;
    sendReq(makeReq(ctxRegPkg::RegRead, 0, '0, 1, 2));
    waitResponses();
    returnFromIrq();
    checkValue("curLevel", 32'd3, 32'(curLevel));
    returnFromIrq();
    checkValue("curLevel", 32'd0, 32'(curLevel));
    returnFromIrq();  // nothing stacked
    checkValue("curLevel", 32'd0, 32'(curLevel));
  endtask

  task automatic credits();
    int baseResp;
    int baseCredits;
    curTest     = "credits";
    holdCredits = 1'b1;
    baseResp    = respCount;
    baseCredits = creditsBack;
    sendReq(makeReq(ctxRegPkg::RegWrite, 10, $random(seed), 0, 0));
    sendReq(makeReq(ctxRegPkg::RegReadWrite, 11, $random(seed), 10, 11));
    sendReq(makeReq(ctxRegPkg::RegRead, 0, '0, 10, 2));
    sendReq(makeReq(ctxRegPkg::RegRead, 0, '0, 11, 1));
    repeat (12) cycle();
    checkValue("heldResponses", `CTX_RESP_CREDITS, respCount - baseResp);
    holdCredits = 1'b0;
    waitResponses();
    checkValue("responses", 32'd4, respCount - baseResp);
    checkValue("reqCredits", 32'd4, creditsBack - baseCredits);
  endtask

  task automatic resetState();
    curTest = "resetState";
    enterIrq(4);
    sendReq(makeReq(ctxRegPkg::RegWrite, 7, $random(seed), 0, 0));
    sendReq(makeReq(ctxRegPkg::RegWrite, 2, $random(seed), 0, 0));
    waitResponses();
    holdCredits = 1'b1;  // two writes stay queued into the reset
    for (int k = 0; k < `CTX_REQ_DEPTH; k++) begin
      sendReq(makeReq(ctxRegPkg::RegWrite, 12 + k, $random(seed), 0, 0));
    end
    repeat (4) cycle();
    reset <= 1'b1;
    repeat (3) cycle();
    reset <= 1'b0;
    clearModel();
    expQ.delete();  // queued requests are dropped by reset
    creditsBack = sentCount;
    owed        = 0;
    holdCredits = 1'b0;
    cycle();
    checkValue("curLevel", 32'd0, 32'(curLevel));
    checkNoAck(6);  // also flags any stray response
    for (int k = 0; k < `CTX_NUM_REGS / 2; k++) begin
      sendReq(makeReq(ctxRegPkg::RegRead, 0, '0, 2 * k, 2 * k + 1));
    end
    waitResponses();
  endtask

  initial begin
    errors      = 0;
    checks      = 0;
    sentCount   = 0;
    creditsBack = 0;
    respCount   = 0;
    owed        = 0;
    holdCredits = 1'b0;
    seed        = 32'h87f0;
    curTest     = "reset";
    reset       = 1'b1;
    reqValid    = 1'b0;
    req         = '0;
    respCredit  = 1'b0;
    irqPending  = '0;
    irqReturn   = 1'b0;
    clearModel();
    repeat (3) cycle();
    reset <= 1'b0;
    basicAccess();
    irqBanking();
    nesting();
    credits();
    resetState();
    repeat (4) cycle();
    finishRun();
  end

endmodule

// File: sim.f
+incdir+rtl
rtl/ctxRegPkg.sv
rtl/rfStack.sv
rtl/irqLevelCtrl.sv
rtl/regReqQueue.sv
rtl/ctxRegTop.sv
verif/ctxRegTb.sv

// File: Makefile
# Verilator simulation of the register context unit
TOP = ctxRegTb

sim:
	verilator --binary -j 0 -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

.PHONY: sim clean
